//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mem_stage_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/axi_if.sv
`default_nettype none
`timescale 1ns/100ps

interface axi_if import rv_pkg::*, axi_pkg::*; ();

    logic       awvalid, awready;
    xlen_t      awaddr;
    axi_id_t    awid;
    logic [7:0] awlen;
    logic [2:0] awsize;
    logic [1:0] awburst;

    logic       wvalid, wready;
    xlen_t      wdata;
    logic [3:0] wstrb;
    logic       wlast;

    logic       bvalid, bready;
    axi_resp_t  bresp;
    axi_id_t    bid;

    logic       arvalid, arready;
    xlen_t      araddr;
    axi_id_t    arid;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;

    logic       rvalid, rready;
    xlen_t      rdata;
    axi_resp_t  rresp;
    logic       rlast;
    axi_id_t    rid;

    modport master (
        output awvalid, awaddr, awid, awlen, awsize, awburst, input awready,
        output wvalid, wdata, wstrb, wlast, input wready,
        input bvalid, bresp, bid, output bready,
        output arvalid, araddr, arid, arlen, arsize, arburst, input arready,
        input rvalid, rdata, rresp, rlast, rid, output rready
    );

    modport slave (
        input awvalid, awaddr, awid, awlen, awsize, awburst, output awready,
        input wvalid, wdata, wstrb, wlast, output wready,
        output bvalid, bresp, bid, input bready,
        input arvalid, araddr, arid, arlen, arsize, arburst, output arready,
        output rvalid, rdata, rresp, rlast, rid, input rready
    );

endinterface

`default_nettype wire

//--- common/axi_pkg.sv
`default_nettype none

package axi_pkg;

    typedef logic [1:0] axi_resp_t;
    typedef logic [3:0] axi_id_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    localparam axi_id_t AXI_ID_STORE = 4'd1;
    localparam axi_id_t AXI_ID_LOAD  = 4'd0;

    localparam logic [7:0] AXI_LEN_SINGLE  = 8'd0;    // one beat
    localparam logic [1:0] AXI_BURST_FIXED = 2'b00;
    localparam logic [2:0] AXI_SIZE_WORD   = 3'b010;  // 4 bytes

    // byte address width of the on-chip sram, 1 KiB
    localparam int SRAM_ADDR_BITS = 10;

endpackage

`default_nettype wire

//--- common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;

    // load width and sign codes
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // store width codes
    localparam funct3_t F3_SB  = 3'b000;
    localparam funct3_t F3_SH  = 3'b001;
    localparam funct3_t F3_SW  = 3'b010;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // one read word, seen as lanes of bytes or halves
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } load_word_u;

endpackage

`default_nettype wire

//--- design/axi_sram.sv
`default_nettype none
`timescale 1ns/100ps

module axi_sram import rv_pkg::*, axi_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    axi_if.slave  bus
);

    xlen_t      mem [2 ** (SRAM_ADDR_BITS - 2)];

    logic       aw_taken;
    logic       w_taken;
    xlen_t      awaddr_q;
    axi_id_t    awid_q;
    xlen_t      wdata_q;
    logic [3:0] wstrb_q;

    logic       aw_hs;
    logic       w_hs;
    logic       ar_hs;
    logic       wr_fire;
    xlen_t      wr_addr;
    axi_id_t    wr_id;
    xlen_t      wr_data;
    logic [3:0] wr_strb;
    logic       wr_err;
    logic       rd_err;

    assign bus.awready = !aw_taken && !bus.bvalid;
    assign bus.wready  = !w_taken && !bus.bvalid;
    assign bus.arready = !bus.rvalid;
    assign bus.rlast   = 1'b1;

    assign aw_hs = bus.awvalid && bus.awready;
    assign w_hs  = bus.wvalid && bus.wready;
    assign ar_hs = bus.arvalid && bus.arready;

    // aw and w may arrive in either order
    assign wr_fire = (aw_taken || aw_hs) && (w_taken || w_hs);
    assign wr_addr = aw_taken ? awaddr_q : bus.awaddr;
    assign wr_id   = aw_taken ? awid_q : bus.awid;
    assign wr_data = w_taken ? wdata_q : bus.wdata;
    assign wr_strb = w_taken ? wstrb_q : bus.wstrb;

    assign wr_err = |wr_addr[31:SRAM_ADDR_BITS];
    assign rd_err = |bus.araddr[31:SRAM_ADDR_BITS];

    always_ff @(posedge clock) begin
        if (reset) begin
            aw_taken   <= 1'b0;
            w_taken    <= 1'b0;
            bus.bvalid <= 1'b0;
        end else if (wr_fire) begin
            aw_taken   <= 1'b0;
            w_taken    <= 1'b0;
            bus.bvalid <= 1'b1;
        end else begin
            if (aw_hs)
                aw_taken <= 1'b1;
            if (w_hs)
                w_taken <= 1'b1;
            if (bus.bvalid && bus.bready)
                bus.bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (aw_hs) begin
            awaddr_q <= bus.awaddr;
            awid_q   <= bus.awid;
        end
        if (w_hs) begin
            wdata_q <= bus.wdata;
            wstrb_q <= bus.wstrb;
        end
        if (wr_fire) begin
            bus.bid   <= wr_id;
            bus.bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_fire && !wr_err && wr_strb[i])
                mem[wr_addr[SRAM_ADDR_BITS-1:2]][8*i +: 8] <= wr_data[8*i +: 8];
        end
    end

    always_ff @(posedge clock) begin
        if (reset)
            bus.rvalid <= 1'b0;
        else if (ar_hs)
            bus.rvalid <= 1'b1;
        else if (bus.rvalid && bus.rready)
            bus.rvalid <= 1'b0;
    end

    always_ff @(posedge clock) begin
        if (ar_hs) begin
            bus.rid   <= bus.arid;
            bus.rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
            bus.rdata <= rd_err ? '0 : mem[bus.araddr[SRAM_ADDR_BITS-1:2]];
        end
    end

    // strobes are built by the master from funct3
    a_wstrb_nonzero: assert property (@(posedge clock) disable iff (reset)
        bus.wvalid |-> bus.wstrb != 4'b0000);

endmodule

`default_nettype wire

//--- design/mem_stage_top.sv
`default_nettype none
`timescale 1ns/100ps

module mem_stage_top import rv_pkg::*; (
    input  logic      clock,
    input  logic      reset,

    input  logic      in_valid,
    output logic      in_ready,
    input  mem_op_e   in_op,
    input  funct3_t   in_funct3,
    input  xlen_t     in_pc,
    input  xlen_t     in_addr,
    input  xlen_t     in_store_data,
    input  reg_addr_t in_rd,
    input  logic      in_reg_wen,

    output logic      out_valid,
    input  logic      out_ready,
    output xlen_t     out_pc,
    output reg_addr_t out_rd,
    output logic      out_reg_wen,
    output xlen_t     out_result,
    output logic      out_fault
);

    funct3_t hold_funct3;
    xlen_t   hold_addr;
    xlen_t   hold_store_data;
    xlen_t   load_value;

    axi_if bus ();

    lsu_ctrl u_ctrl (
        .clock           (clock),
        .reset           (reset),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_op           (in_op),
        .in_funct3       (in_funct3),
        .in_pc           (in_pc),
        .in_addr         (in_addr),
        .in_store_data   (in_store_data),
        .in_rd           (in_rd),
        .in_reg_wen      (in_reg_wen),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_pc          (out_pc),
        .out_result      (out_result),
        .out_rd          (out_rd),
        .out_reg_wen     (out_reg_wen),
        .out_fault       (out_fault),
        .hold_funct3     (hold_funct3),
        .hold_addr       (hold_addr),
        .hold_store_data (hold_store_data),
        .load_value      (load_value),
        .bus             (bus.master)
    );

    lsu_align u_align (
        .funct3     (hold_funct3),
        .addr       (hold_addr),
        .store_data (hold_store_data),
        .load_value (load_value),
        .bus        (bus.master)
    );

    axi_sram u_sram (
        .clock (clock),
        .reset (reset),
        .bus   (bus.slave)
    );

endmodule

`default_nettype wire

//--- lsu/lsu_align.sv
`default_nettype none
`timescale 1ns/100ps

module lsu_align import rv_pkg::*, axi_pkg::*; (
    input  funct3_t   funct3,
    input  xlen_t     addr,
    input  xlen_t     store_data,
    output xlen_t     load_value,
    axi_if.master     bus
);

    logic [1:0]  offset;
    load_word_u  rword;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign offset = addr[1:0];

    // write address stays unaligned, lanes come from wstrb
    assign bus.awaddr  = addr;
    assign bus.awlen   = AXI_LEN_SINGLE;
    assign bus.awburst = AXI_BURST_FIXED;
    assign bus.wdata   = store_data << {offset, 3'b000};
    assign bus.wlast   = 1'b1;

    assign bus.araddr  = {addr[31:2], 2'b00};
    assign bus.arlen   = AXI_LEN_SINGLE;
    assign bus.arsize  = AXI_SIZE_WORD;
    assign bus.arburst = AXI_BURST_FIXED;

    always_comb begin
        case (funct3)
            F3_SB: begin
                bus.wstrb  = 4'b0001 << offset;
                bus.awsize = 3'b000;
            end
            F3_SH: begin
                bus.wstrb  = 4'b0011 << offset;
                bus.awsize = 3'b001;
            end
            F3_SW: begin
                bus.wstrb  = 4'b1111;
                bus.awsize = 3'b010;
            end
            default: begin
                bus.wstrb  = 4'b0000;               // no lanes for an illegal width
                bus.awsize = 3'b010;
            end
        endcase
    end

    assign rword = bus.rdata;

    always_comb begin
        sel_byte = rword.bytes[offset];
        sel_half = rword.halves[offset[1]];
        case (funct3)
            F3_LB:   load_value = {{24{sel_byte[7]}}, sel_byte};
            F3_LH:   load_value = {{16{sel_half[15]}}, sel_half};
            F3_LBU:  load_value = {24'd0, sel_byte};
            F3_LHU:  load_value = {16'd0, sel_half};
            default: load_value = rword;            // lw
        endcase
    end

endmodule

`default_nettype wire

//--- lsu/lsu_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module lsu_ctrl import rv_pkg::*, axi_pkg::*; (
    input  logic      clock,
    input  logic      reset,

    input  logic      in_valid,
    output logic      in_ready,
    input  mem_op_e   in_op,
    input  funct3_t   in_funct3,
    input  xlen_t     in_pc,
    input  xlen_t     in_addr,
    input  xlen_t     in_store_data,
    input  reg_addr_t in_rd,
    input  logic      in_reg_wen,

    output logic      out_valid,
    input  logic      out_ready,
    output xlen_t     out_pc,
    output xlen_t     out_result,
    output reg_addr_t out_rd,
    output logic      out_reg_wen,
    output logic      out_fault,

    output funct3_t   hold_funct3,
    output xlen_t     hold_addr,
    output xlen_t     hold_store_data,
    input  xlen_t     load_value,

    axi_if.master     bus
);

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        DONE
    } state_e;

    state_e state;
    logic   accept;
    logic   leave;
    logic   is_load;
    logic   is_store;
    logic   r_done;
    logic   b_done;

    assign out_valid = (state == DONE);
    assign leave     = out_valid && out_ready;
    assign in_ready  = (state == IDLE) || leave;   // refill in the same cycle
    assign accept    = in_valid && in_ready;
    assign is_load   = (in_op == MEM_LOAD);
    assign is_store  = (in_op == MEM_STORE);
    assign r_done    = bus.rvalid && bus.rready;
    assign b_done    = bus.bvalid && bus.bready;

    assign bus.awid = AXI_ID_STORE;
    assign bus.arid = AXI_ID_LOAD;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else if (accept) begin
            state <= (is_load || is_store) ? BUS : DONE;
        end else if (leave) begin
            state <= IDLE;
        end else if (r_done || b_done) begin
            state <= DONE;                           // out_valid one cycle after response
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bus.arvalid <= 1'b0;
            bus.rready  <= 1'b0;
            bus.awvalid <= 1'b0;
            bus.wvalid  <= 1'b0;
            bus.bready  <= 1'b0;
        end else if (accept) begin
            bus.arvalid <= is_load;
            bus.rready  <= is_load;
            bus.awvalid <= is_store;
            bus.wvalid  <= is_store;
            bus.bready  <= is_store;
        end else begin
            if (bus.arvalid && bus.arready)
                bus.arvalid <= 1'b0;
            if (r_done)
                bus.rready <= 1'b0;
            if (bus.awvalid && bus.awready)
                bus.awvalid <= 1'b0;
            if (bus.wvalid && bus.wready)
                bus.wvalid <= 1'b0;
            if (b_done)
                bus.bready <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            out_pc          <= in_pc;
            out_rd          <= in_rd;
            out_reg_wen     <= in_reg_wen;
            out_result      <= in_addr;              // alu result passes through
            out_fault       <= 1'b0;
            hold_funct3     <= in_funct3;
            hold_addr       <= in_addr;
            hold_store_data <= in_store_data;
        end else if (r_done) begin
            out_result <= load_value;
            out_fault  <= (bus.rresp != RESP_OKAY);
        end else if (b_done) begin
            out_fault <= (bus.bresp != RESP_OKAY);
        end
    end

    a_ar_hold: assert property (@(posedge clock) disable iff (reset)
        bus.arvalid && !bus.arready |=> bus.arvalid);

    a_aw_hold: assert property (@(posedge clock) disable iff (reset)
        bus.awvalid && !bus.awready |=> bus.awvalid);

    // a stalled item is not replaced by a new one
    a_no_accept_stalled: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_pc) && $stable(out_result)
            && $stable(out_rd) && $stable(out_reg_wen) && $stable(out_fault));

    // slave must echo the request id on single-beat responses
    a_resp_id_r: assert property (@(posedge clock) disable iff (reset)
        r_done |-> bus.rid == AXI_ID_LOAD && bus.rlast);

    a_resp_id_b: assert property (@(posedge clock) disable iff (reset)
        b_done |-> bus.bid == AXI_ID_STORE);

endmodule

`default_nettype wire

//--- sources.f
common/rv_pkg.sv
common/axi_pkg.sv
common/axi_if.sv
lsu/lsu_align.sv
lsu/lsu_ctrl.sv
design/axi_sram.sv
design/mem_stage_top.sv
tb/tb_clock.sv
tb/mem_stage_tb.sv

//--- tb/mem_stage_tb.sv
`default_nettype none
`timescale 1ns/100ps

module mem_stage_tb import rv_pkg::*; ();

    localparam int SEED      = 75088;
    localparam int N_FILL    = 256;      // one store per sram word
    localparam int N_PASS    = 30;
    localparam int N_STLD    = 40;       // store and load pairs
    localparam int N_EXT     = 64;
    localparam int N_FAULT   = 10;       // three items each
    localparam int N_MIX     = 100;
    localparam int N_ITEMS   = N_FILL + N_PASS + 2 * N_STLD + N_EXT + 3 * N_FAULT + N_MIX;
    localparam int MAX_CYCLES = 40 * N_ITEMS + 100;
    localparam funct3_t EXT_CODES [4] = '{F3_LB, F3_LBU, F3_LH, F3_LHU};

    typedef struct packed {
        xlen_t     pc;
        xlen_t     result;
        reg_addr_t rd;
        logic      reg_wen;
        logic      fault;
    } expect_t;

    logic      clock;
    logic      reset;
    logic      in_valid, in_ready, in_reg_wen;
    mem_op_e   in_op;
    funct3_t   in_funct3;
    xlen_t     in_pc, in_addr, in_store_data;
    reg_addr_t in_rd;
    logic      out_valid, out_ready, out_reg_wen, out_fault;
    xlen_t     out_pc, out_result;
    reg_addr_t out_rd;

    logic [7:0] model_mem [0:1023];
    expect_t    exp_q [$];
    expect_t    head;
    int         n_sent, n_out, cycles;
    logic [7:0] w;
    funct3_t    f3;
    xlen_t      a;
    int         kind;
    logic       far;

    tb_clock clock_gen (.clock(clock));

    mem_stage_top dut (.*);

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t want);
        if (got !== want) begin
            $display("FAIL %s got %h expected %h", name, got, want);
            stop_run();
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t want);
        if (got !== want) begin
            $display("FAIL %s got %h expected %h", name, got, want);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("FAIL %s got %h expected %h", name, got, want);
            stop_run();
        end
    endtask

    // every byte of the word depends on the whole word index
    function automatic xlen_t fill_word(input logic [7:0] idx);
        return {idx ^ 8'ha5, ~idx, idx, idx ^ 8'h3c};
    endfunction

    function automatic funct3_t pick_load_f3();
        case ($urandom % 5)
            0: return F3_LB;
            1: return F3_LH;
            2: return F3_LW;
            3: return F3_LBU;
            default: return F3_LHU;
        endcase
    endfunction

    function automatic funct3_t pick_store_f3();
        case ($urandom % 3)
            0: return F3_SB;
            1: return F3_SH;
            default: return F3_SW;
        endcase
    endfunction

    // halves on 2-byte, words on 4-byte boundaries
    function automatic xlen_t store_addr(input funct3_t code, input logic [7:0] idx);
        logic [1:0] off;
        off = 2'($urandom);
        case (code)
            F3_SB: return {22'd0, idx, off};
            F3_SH: return {22'd0, idx, off[1], 1'b0};
            default: return {22'd0, idx, 2'b00};
        endcase
    endfunction

    task automatic model_item(input mem_op_e op, input funct3_t code, input xlen_t addr,
                              input xlen_t data);
        expect_t     e;
        logic [9:0]  ba;
        logic [9:0]  hb;
        logic [7:0]  b;
        logic [15:0] h;
        xlen_t       word;
        ba   = addr[9:0];
        hb   = {ba[9:1], 1'b0};                  // half chosen by address bit 1
        b    = model_mem[ba];
        h    = {model_mem[{ba[9:1], 1'b1}], model_mem[hb]};
        word = {model_mem[{ba[9:2], 2'd3}], model_mem[{ba[9:2], 2'd2}],
                model_mem[{ba[9:2], 2'd1}], model_mem[{ba[9:2], 2'd0}]};
        e.pc      = in_pc;
        e.rd      = in_rd;
        e.reg_wen = in_reg_wen;
        e.result  = addr;
        e.fault   = (op != MEM_NONE) && (addr[31:10] != 22'd0);
        if (op == MEM_LOAD && e.fault) begin
            e.result = '0;
        end else if (op == MEM_LOAD) begin
            case (code)
                F3_LB:   e.result = {{24{b[7]}}, b};
                F3_LH:   e.result = {{16{h[15]}}, h};
                F3_LBU:  e.result = {24'd0, b};
                F3_LHU:  e.result = {16'd0, h};
                default: e.result = word;
            endcase
        end else if (op == MEM_STORE && !e.fault) begin
            model_mem[ba] = data[7:0];
            if (code != F3_SB)
                model_mem[{ba[9:1], 1'b1}] = data[15:8];
            if (code == F3_SW) begin
                model_mem[{ba[9:2], 2'd2}] = data[23:16];
                model_mem[{ba[9:2], 2'd3}] = data[31:24];
            end
        end
        exp_q.push_back(e);
        n_sent++;
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic send_item(input mem_op_e op, input funct3_t code, input xlen_t addr,
                             input xlen_t data);
        logic taken;
        in_valid      = 1'b1;
        in_op         = op;
        in_funct3     = code;
        in_addr       = addr;
        in_store_data = data;
        in_pc         = $urandom;
        in_rd         = reg_addr_t'($urandom);
        in_reg_wen    = 1'($urandom);
        taken         = 1'b0;
        while (!taken) begin
            @(negedge clock);
            if (in_ready) begin
                taken = 1'b1;
                model_item(op, code, addr, data);
            end
            @(posedge clock);
            #1;
        end
        in_valid = 1'b0;
    endtask

    always @(negedge clock) begin
        if (!reset && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("an output item appeared with no input item pending");
                stop_run();
            end else begin
                head = exp_q.pop_front();
                check_word("out_pc", out_pc, head.pc);
                check_word("out_result", out_result, head.result);
                check_reg("out_rd", out_rd, head.rd);
                check_flag("out_reg_wen", out_reg_wen, head.reg_wen);
                check_flag("out_fault", out_fault, head.fault);
                n_out++;
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d items out", cycles, n_out, N_ITEMS);
            stop_run();
        end
    end

    initial begin
        void'($urandom(SEED));
        reset = 1'b1;
        in_valid = 1'b0;
        in_op = MEM_NONE;
        in_funct3 = '0;
        in_pc = '0;
        in_addr = '0;
        in_store_data = '0;
        in_rd = '0;
        in_reg_wen = 1'b0;
        out_ready = 1'b0;
        n_sent = 0;
        n_out = 0;
        cycles = 0;
        fork
            forever begin
                @(posedge clock);
                #1;
                out_ready = ($urandom % 10) >= 3;   // low about 30 percent
            end
        join_none
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;

        for (int i = 0; i < N_FILL; i++)
            send_item(MEM_STORE, F3_SW, {22'd0, 8'(i), 2'b00}, fill_word(8'(i)));

        for (int i = 0; i < N_PASS; i++)
            send_item(MEM_NONE, funct3_t'($urandom), $urandom, $urandom);

        for (int i = 0; i < N_STLD; i++) begin
            w  = 8'($urandom);
            f3 = pick_store_f3();
            send_item(MEM_STORE, f3, store_addr(f3, w), $urandom);
            send_item(MEM_LOAD, F3_LW, {22'd0, w, 2'b00}, $urandom);
        end

        for (int c = 0; c < 4; c++) begin
            for (int off = 0; off < 4; off++) begin
                for (int k = 0; k < N_EXT / 16; k++) begin
                    w = 8'($urandom);
                    send_item(MEM_LOAD, EXT_CODES[c], {22'd0, w, 2'(off)}, $urandom);
                end
            end
        end

        // out of range store, load of the aliased word, out of range load
        for (int i = 0; i < N_FAULT; i++) begin
            a = $urandom | 32'h0000_0400;
            a[1:0] = 2'b00;
            send_item(MEM_STORE, F3_SW, a, $urandom);
            send_item(MEM_LOAD, F3_LW, {22'd0, a[9:2], 2'b00}, $urandom);
            send_item(MEM_LOAD, pick_load_f3(), $urandom | 32'h0000_0400, $urandom);
        end

        for (int i = 0; i < N_MIX; i++) begin
            kind = $urandom % 3;
            far  = ($urandom % 10) == 0;
            w    = 8'($urandom);
            if (kind == 0) begin
                send_item(MEM_NONE, funct3_t'($urandom), $urandom, $urandom);
            end else if (kind == 1) begin
                f3 = pick_load_f3();
                a  = {22'd0, w, (f3 == F3_LW) ? 2'b00 : 2'($urandom)};
                if (far)
                    a[31:10] = 22'($urandom) | 22'd1;
                send_item(MEM_LOAD, f3, a, $urandom);
            end else begin
                f3 = pick_store_f3();
                a  = store_addr(f3, w);
                if (far)
                    a[31:10] = 22'($urandom) | 22'd1;
                send_item(MEM_STORE, f3, a, $urandom);
            end
        end

        while (exp_q.size() != 0)
            @(posedge clock);
        repeat (10) @(posedge clock);   // catch late duplicates
        if (n_out == n_sent && n_sent == N_ITEMS) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("item counts differ: %0d sent, %0d received", n_sent, n_out);
            stop_run();
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock (
    output logic clock
);

    localparam real HALF_PERIOD = 2.0;   // 4 ns period

    initial begin
        clock = 1'b0;
        forever begin
            #(HALF_PERIOD);
            clock = ~clock;
        end
    end

endmodule

`default_nettype wire
